// File: verilog/lc3b_types.sv
package lc3b_types;

typedef logic [15:0] lc3b_word;
typedef logic [2:0]  lc3b_reg;
// negative, zero, positive from msb to lsb
typedef logic [2:0]  lc3b_nzp;

typedef enum logic [3:0] {
    op_br   = 4'b0000,
    op_add  = 4'b0001,
    op_ldb  = 4'b0010,
    op_stb  = 4'b0011,
    op_jsr  = 4'b0100,
    op_and  = 4'b0101,
    op_ldr  = 4'b0110,
    op_str  = 4'b0111,
    op_rti  = 4'b1000,
    op_not  = 4'b1001,
    op_ldi  = 4'b1010,
    op_sti  = 4'b1011,
    op_jmp  = 4'b1100,
    op_shf  = 4'b1101,
    op_lea  = 4'b1110,
    op_trap = 4'b1111
} lc3b_opcode;

typedef enum logic {
    fwd_none = 1'b0,
    fwd_wb   = 1'b1
} lc3b_fwd_sel;

// BR with no condition bits set, never taken
localparam lc3b_word nop_instr = 16'h0000;

function automatic lc3b_opcode get_opcode(lc3b_word ir);
    return lc3b_opcode'(ir[15:12]);
endfunction

function automatic lc3b_word sext_imm5(lc3b_word ir);
    return {{11{ir[4]}}, ir[4:0]};
endfunction

// offset counts words, the target is a byte address
function automatic lc3b_word sext_off9(lc3b_word ir);
    return {{6{ir[8]}}, ir[8:0], 1'b0};
endfunction

function automatic lc3b_nzp gen_nzp(lc3b_word value);
    if (value[15]) begin
        return 3'b100;
    end else if (value == 16'h0000) begin
        return 3'b010;
    end
    return 3'b001;
endfunction

endpackage : lc3b_types

// File: verilog/pipeline_control.sv
`timescale 1ns/1ns

module pipeline_control
    import lc3b_types::*;
(
    input  logic        imem_wait,
    input  logic        branch_taken,

    // source registers of the instruction in execute
    input  logic        id_ex_valid,
    input  lc3b_reg     id_ex_sr1,
    input  lc3b_reg     id_ex_sr2,

    // instruction currently writing back
    input  logic        ex_wb_valid,
    input  lc3b_reg     ex_wb_dest,

    output logic        pc_hold,
    output logic        flush_if_id,
    output logic        flush_id_ex,
    output lc3b_fwd_sel fwd_a,
    output lc3b_fwd_sel fwd_b
);

logic hit_a;
logic hit_b;

// a redirect must not be lost while memory is busy
assign pc_hold = imem_wait & ~branch_taken;

// both younger slots hold wrong-path instructions
assign flush_if_id = branch_taken;
assign flush_id_ex = branch_taken;

// ex_wb_valid is only high for register writing instructions
assign hit_a = id_ex_valid && ex_wb_valid && (ex_wb_dest == id_ex_sr1);
assign hit_b = id_ex_valid && ex_wb_valid && (ex_wb_dest == id_ex_sr2);

always_comb begin
    fwd_a = fwd_none;
    fwd_b = fwd_none;
    if (hit_a) begin
        fwd_a = fwd_wb;
    end
    if (hit_b) begin
        fwd_b = fwd_wb;
    end
end

endmodule : pipeline_control

// File: verilog/fetch_stage.sv
`timescale 1ns/1ns

module fetch_stage
    import lc3b_types::*;
#(
    parameter lc3b_word reset_pc = 16'h0000
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     pc_hold,
    input  logic     flush,
    input  logic     branch_taken,
    input  lc3b_word branch_target,
    input  logic     imem_wait,
    output lc3b_word imem_addr,
    input  lc3b_word imem_data,
    output lc3b_word if_id_ir,
    output lc3b_word if_id_pc,
    output logic     if_id_valid
);

lc3b_word pc;
lc3b_word pc_plus2;
lc3b_word next_pc;
logic     bubble;

assign pc_plus2  = pc + 16'd2;
assign imem_addr = pc;
assign bubble    = flush | imem_wait;

// redirect beats a hold
always_comb begin
    next_pc = pc_plus2;
    if (branch_taken) begin
        next_pc = branch_target;
    end else if (pc_hold) begin
        next_pc = pc;
    end
end

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        pc          <= reset_pc;
        if_id_valid <= 1'b0;
    end else begin
        pc          <= next_pc;
        if_id_valid <= ~bubble;
    end
end

// if_id_pc is the fall-through address used for branch targets
always_ff @(posedge clk) begin
    if (bubble) begin
        if_id_ir <= nop_instr;
    end else begin
        if_id_ir <= imem_data;
    end
    if_id_pc <= pc_plus2;
end

endmodule : fetch_stage

// File: verilog/decode_stage.sv
`timescale 1ns/1ns

module decode_stage
    import lc3b_types::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       flush,

    // IF/ID barrier
    input  lc3b_word   if_id_ir,
    input  lc3b_word   if_id_pc,
    input  logic       if_id_valid,

    // register file write from writeback
    input  logic       wb_valid,
    input  lc3b_reg    wb_dest,
    input  lc3b_word   wb_data,

    // ID/EX barrier
    output lc3b_opcode id_ex_op,
    output lc3b_reg    id_ex_sr1,
    output lc3b_reg    id_ex_sr2,
    output lc3b_reg    id_ex_dest,
    output lc3b_word   id_ex_a,
    output lc3b_word   id_ex_b,
    output lc3b_word   id_ex_imm,
    output logic       id_ex_use_imm,
    output lc3b_nzp    id_ex_nzp,
    output lc3b_word   id_ex_pc,
    output logic       id_ex_valid
);

lc3b_word   regs [8];
lc3b_opcode op;
lc3b_reg    sr1;
lc3b_reg    sr2;
lc3b_word   rd_a;
lc3b_word   rd_b;
lc3b_word   imm;

assign op  = get_opcode(if_id_ir);
assign sr1 = if_id_ir[8:6];
assign sr2 = if_id_ir[2:0];
assign imm = (op == op_br) ? sext_off9(if_id_ir) : sext_imm5(if_id_ir);

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        for (int i = 0; i < 8; i++) begin
            regs[i] <= 16'h0000;
        end
    end else if (wb_valid) begin
        regs[wb_dest] <= wb_data;
    end
end

// write-through so a read in the write cycle sees the new value
always_comb begin
    rd_a = regs[sr1];
    rd_b = regs[sr2];
    if (wb_valid && (wb_dest == sr1)) begin
        rd_a = wb_data;
    end
    if (wb_valid && (wb_dest == sr2)) begin
        rd_b = wb_data;
    end
end

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        id_ex_valid <= 1'b0;
    end else begin
        id_ex_valid <= if_id_valid & ~flush;
    end
end

// dest and nzp share bits 11:9, which one matters depends on the opcode
always_ff @(posedge clk) begin
    id_ex_op      <= op;
    id_ex_sr1     <= sr1;
    id_ex_sr2     <= sr2;
    id_ex_dest    <= if_id_ir[11:9];
    id_ex_nzp     <= if_id_ir[11:9];
    id_ex_a       <= rd_a;
    id_ex_b       <= rd_b;
    id_ex_imm     <= imm;
    id_ex_use_imm <= if_id_ir[5];
    id_ex_pc      <= if_id_pc;
end

endmodule : decode_stage

// File: verilog/execute_stage.sv
`timescale 1ns/1ns

module execute_stage
    import lc3b_types::*;
(
    input  logic        clk,
    input  logic        rst_n,

    // ID/EX barrier
    input  lc3b_opcode  id_ex_op,
    input  lc3b_reg     id_ex_sr1,
    input  lc3b_reg     id_ex_sr2,
    input  lc3b_reg     id_ex_dest,
    input  lc3b_word    id_ex_a,
    input  lc3b_word    id_ex_b,
    input  lc3b_word    id_ex_imm,
    input  logic        id_ex_use_imm,
    input  lc3b_nzp     id_ex_nzp,
    input  lc3b_word    id_ex_pc,
    input  logic        id_ex_valid,

    input  lc3b_fwd_sel fwd_a,
    input  lc3b_fwd_sel fwd_b,

    output logic        branch_taken,
    output lc3b_word    branch_target,

    // EX/WB barrier
    output logic        wb_valid,
    output lc3b_reg     wb_dest,
    output lc3b_word    wb_data
);

lc3b_word op_a;
lc3b_word op_b;
lc3b_word alu_b;
lc3b_word alu_out;
lc3b_nzp  cc;
logic     writes;

// the result in EX/WB is one instruction ahead
assign op_a  = (fwd_a == fwd_wb) ? wb_data : id_ex_a;
assign op_b  = (fwd_b == fwd_wb) ? wb_data : id_ex_b;
assign alu_b = id_ex_use_imm ? id_ex_imm : op_b;

always_comb begin
    alu_out = op_a + alu_b;
    writes  = 1'b0;
    unique case (id_ex_op)
        op_add: begin
            alu_out = op_a + alu_b;
            writes  = id_ex_valid;
        end
        op_and: begin
            alu_out = op_a & alu_b;
            writes  = id_ex_valid;
        end
        op_not: begin
            alu_out = ~op_a;
            writes  = id_ex_valid;
        end
        // everything else passes through as a no-op
        default: begin
            writes = 1'b0;
        end
    endcase
end

// codes come from the last instruction that left execute
assign branch_taken  = id_ex_valid && (id_ex_op == op_br) && |(id_ex_nzp & cc);
assign branch_target = id_ex_pc + id_ex_imm;

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        cc       <= 3'b010;
        wb_valid <= 1'b0;
    end else begin
        wb_valid <= writes;
        if (writes) begin
            cc <= gen_nzp(alu_out);
        end
    end
end

always_ff @(posedge clk) begin
    wb_dest <= id_ex_dest;
    wb_data <= alu_out;
end

endmodule : execute_stage

// File: verilog/cpu.sv
`timescale 1ns/1ns

module cpu
    import lc3b_types::*;
#(
    parameter lc3b_word reset_pc = 16'h0000
) (
    input  logic     clk,
    input  logic     rst_n,

    // instruction fetch
    output lc3b_word imem_addr,
    input  lc3b_word imem_data,
    input  logic     imem_wait,

    // register writeback
    output logic     wb_valid,
    output lc3b_reg  wb_dest,
    output lc3b_word wb_data
);

logic        pc_hold;
logic        flush_if_id;
logic        flush_id_ex;
lc3b_fwd_sel fwd_a;
lc3b_fwd_sel fwd_b;
logic        branch_taken;
lc3b_word    branch_target;
lc3b_word    if_id_ir;
lc3b_word    if_id_pc;
logic        if_id_valid;
lc3b_opcode  id_ex_op;
lc3b_reg     id_ex_sr1;
lc3b_reg     id_ex_sr2;
lc3b_reg     id_ex_dest;
lc3b_word    id_ex_a;
lc3b_word    id_ex_b;
lc3b_word    id_ex_imm;
logic        id_ex_use_imm;
lc3b_nzp     id_ex_nzp;
lc3b_word    id_ex_pc;
logic        id_ex_valid;

pipeline_control u_control (
    .imem_wait, .branch_taken, .id_ex_valid, .id_ex_sr1, .id_ex_sr2,
    .ex_wb_valid(wb_valid), .ex_wb_dest(wb_dest),
    .pc_hold, .flush_if_id, .flush_id_ex, .fwd_a, .fwd_b
);

fetch_stage #(.reset_pc(reset_pc)) u_fetch (
    .clk, .rst_n, .pc_hold, .flush(flush_if_id), .branch_taken, .branch_target,
    .imem_wait, .imem_addr, .imem_data, .if_id_ir, .if_id_pc, .if_id_valid
);

decode_stage u_decode (
    .clk, .rst_n, .flush(flush_id_ex), .if_id_ir, .if_id_pc, .if_id_valid,
    .wb_valid, .wb_dest, .wb_data,
    .id_ex_op, .id_ex_sr1, .id_ex_sr2, .id_ex_dest, .id_ex_a, .id_ex_b,
    .id_ex_imm, .id_ex_use_imm, .id_ex_nzp, .id_ex_pc, .id_ex_valid
);

execute_stage u_execute (
    .clk, .rst_n, .id_ex_op, .id_ex_sr1, .id_ex_sr2, .id_ex_dest, .id_ex_a,
    .id_ex_b, .id_ex_imm, .id_ex_use_imm, .id_ex_nzp, .id_ex_pc, .id_ex_valid,
    .fwd_a, .fwd_b, .branch_taken, .branch_target, .wb_valid, .wb_dest, .wb_data
);

endmodule : cpu

// File: bench/cpu_tb.sv
`timescale 1ns/1ns

module cpu_tb;

localparam logic [15:0] start_pc = 16'h3000;
localparam int max_cycles = 400;
localparam int idle_cycles = 24;

logic        clk = 1'b0;
logic        rst_n;
logic [15:0] imem_addr;
logic [15:0] imem_data;
logic        imem_wait;
logic        wb_valid;
logic [2:0]  wb_dest;
logic [15:0] wb_data;

logic [15:0] prog [64];
int          prog_len;
logic [2:0]  exp_dest [$];
logic [15:0] exp_data [$];
logic        wait_en;
int          cycles;

cpu #(.reset_pc(start_pc)) u_dut (
    .clk, .rst_n, .imem_addr, .imem_data, .imem_wait, .wb_valid, .wb_dest, .wb_data
);

initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
end

task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "simulation stopped at the first error");
endtask

// instruction encoders, offsets and immediates in words
function automatic logic [15:0] add_reg(input int d, input int s1, input int s2);
    return {4'b0001, d[2:0], s1[2:0], 3'b000, s2[2:0]};
endfunction

function automatic logic [15:0] add_imm(input int d, input int s1, input int imm);
    return {4'b0001, d[2:0], s1[2:0], 1'b1, imm[4:0]};
endfunction

function automatic logic [15:0] and_reg(input int d, input int s1, input int s2);
    return {4'b0101, d[2:0], s1[2:0], 3'b000, s2[2:0]};
endfunction

function automatic logic [15:0] and_imm(input int d, input int s1, input int imm);
    return {4'b0101, d[2:0], s1[2:0], 1'b1, imm[4:0]};
endfunction

function automatic logic [15:0] not_reg(input int d, input int s);
    return {4'b1001, d[2:0], s[2:0], 6'b111111};
endfunction

function automatic logic [15:0] branch(input int nzp, input int off);
    return {4'b0000, nzp[2:0], off[8:0]};
endfunction

// outside the program the memory returns register writing ADDs
function automatic logic [15:0] mem_word(input logic [15:0] addr);
    logic [15:0] offs;
    int          idx;
    offs = addr - start_pc;
    idx = {17'd0, offs[15:1]};
    if (idx < prog_len) begin
        return prog[idx];
    end
    return {4'b0001, addr[11:0] ^ addr[15:4]};
endfunction

assign imem_data = mem_word(imem_addr);

task automatic append_instr(input logic [15:0] w);
    prog[prog_len] = w;
    prog_len = prog_len + 1;
endtask

task automatic load_program();
    prog_len = 0;
    append_instr(add_imm(1, 0, 5));
    append_instr(add_imm(2, 1, -3));
    append_instr(add_reg(3, 1, 2));
    append_instr(and_imm(4, 3, 6));
    append_instr(not_reg(5, 4));
    append_instr(branch(3'b100, 2));
    // skipped by the taken BRn
    append_instr(add_imm(6, 6, 13));
    append_instr(add_imm(7, 7, 11));
    append_instr(and_reg(6, 5, 3));
    append_instr(branch(3'b010, 1));
    append_instr(add_imm(7, 6, 15));
    append_instr(add_reg(0, 7, 5));
    append_instr(and_imm(1, 1, 0));
    append_instr(branch(3'b010, 1));
    append_instr(not_reg(2, 2));
    append_instr(add_reg(2, 2, 2));
    append_instr(not_reg(3, 2));
    append_instr(add_imm(3, 3, 1));
    append_instr(branch(3'b101, 1));
    append_instr(and_imm(4, 4, 0));
    append_instr(and_reg(4, 3, 2));
    append_instr(add_imm(5, 0, -9));
    append_instr(branch(3'b001, 2));
    append_instr(not_reg(6, 6));
    append_instr(and_reg(0, 6, 7));
    append_instr(add_reg(1, 0, 4));
    append_instr(branch(3'b000, 0));
    append_instr(add_reg(7, 1, 1));
    append_instr(branch(3'b111, -1));
endtask

// runs the program in order and queues every register write
task automatic build_expected();
    logic [15:0] regs [8];
    logic [2:0]  cc;
    logic [15:0] ir;
    logic [15:0] src_b;
    logic [15:0] val;
    logic        write;
    int          idx;
    int          next_idx;
    int          i;
    for (i = 0; i < 8; i++) begin
        regs[i] = 16'h0000;
    end
    cc = 3'b010;
    idx = 0;
    while (idx >= 0 && idx < prog_len) begin
        ir = prog[idx];
        next_idx = idx + 1;
        write = 1'b1;
        src_b = ir[5] ? {{11{ir[4]}}, ir[4:0]} : regs[ir[2:0]];
        val = 16'h0000;
        case (ir[15:12])
            4'b0001: val = regs[ir[8:6]] + src_b;
            4'b0101: val = regs[ir[8:6]] & src_b;
            4'b1001: val = ~regs[ir[8:6]];
            4'b0000: begin
                write = 1'b0;
                if ((ir[11:9] & cc) != 3'b000) begin
                    next_idx = idx + 1 + int'($signed(ir[8:0]));
                end
            end
            default: write = 1'b0;
        endcase
        if (write) begin
            regs[ir[11:9]] = val;
            cc = val[15] ? 3'b100 : ((val == 16'h0000) ? 3'b010 : 3'b001);
            exp_dest.push_back(ir[11:9]);
            exp_data.push_back(val);
        end
        if (next_idx == idx) begin
            break;
        end
        idx = next_idx;
    end
endtask

// fetch wait is high on about one cycle in four
initial begin
    void'($urandom(45));
    imem_wait = 1'b0;
    forever begin
        @(posedge clk);
        #1;
        imem_wait = wait_en ? (($urandom % 4) == 0) : 1'b0;
    end
end

always @(negedge clk) begin
    if (!rst_n) begin
        assert (!wb_valid)
            else report_fail($sformatf("ERROR wb_valid got %h expected 0", wb_valid));
        assert (imem_addr == start_pc)
            else report_fail($sformatf("ERROR imem_addr got %h expected %h", imem_addr, start_pc));
    end else if (wb_valid) begin
        assert (exp_dest.size() > 0)
            else report_fail("a register write appeared after all expected writes were seen");
        assert (wb_dest == exp_dest[0])
            else report_fail($sformatf("ERROR wb_dest got %h expected %h", wb_dest, exp_dest[0]));
        assert (wb_data == exp_data[0])
            else report_fail($sformatf("ERROR wb_data got %h expected %h", wb_data, exp_data[0]));
        void'(exp_dest.pop_front());
        void'(exp_data.pop_front());
    end
end

always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > max_cycles) begin
        report_fail($sformatf("timeout after %0d cycles with writes still missing", max_cycles));
    end
end

initial begin
    rst_n = 1'b0;
    wait_en = 1'b0;
    cycles = 0;
    load_program();
    build_expected();
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // pc has not moved yet
    @(negedge clk);
    assert (imem_addr == start_pc)
        else report_fail($sformatf("ERROR imem_addr got %h expected %h", imem_addr, start_pc));
    assert (!wb_valid)
        else report_fail($sformatf("ERROR wb_valid got %h expected 0", wb_valid));
    wait_en = 1'b1;
    while (exp_dest.size() != 0) begin
        @(posedge clk);
    end
    // the closing self-loop must stay silent
    repeat (idle_cycles) @(posedge clk);
    $display("Test passed");
    $finish;
end

endmodule : cpu_tb

// File: verilog.f
verilog/lc3b_types.sv
verilog/pipeline_control.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/cpu.sv
bench/cpu_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = cpu_tb
FILELIST  = verilog.f
BUILD     = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	out=$$(./$(BUILD)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(BUILD)
